// File: rtl/axis_fifo_64.sv
// axis_fifo_64: circular stream FIFO for 64-bit beats with a registered output
`timescale 1ns/100ps
`default_nettype none

module axis_fifo_64 #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                            clk,
    input  logic                            rst,

    // plain input stream
    input  logic [axis_pkg::DATA_WIDTH-1:0] in_tdata,
    input  logic [axis_pkg::KEEP_WIDTH-1:0] in_tkeep,
    input  logic                            in_tvalid,
    output logic                            in_tready,
    input  logic                            in_tlast,
    input  logic                            in_tuser,

    // buffered output stream
    axis_if.src                             m
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // storage, no reset on the array
    axis_pkg::axis_beat_t mem [DEPTH];

    // pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0]  wr_ptr;
    logic [ADDR_WIDTH:0]  rd_ptr;

    axis_pkg::axis_beat_t in_beat;
    axis_pkg::axis_beat_t out_beat;
    logic                 out_valid;

    logic                 full;
    logic                 empty;
    logic                 wr_en;
    logic                 rd_en;

    //////////////////////////////
    // status and strobes
    //////////////////////////////

    assign in_beat.tdata = in_tdata;
    assign in_beat.tkeep = in_tkeep;
    assign in_beat.tlast = in_tlast;
    assign in_beat.tuser = in_tuser;

    // wrap bits differ, index bits equal
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_en = in_tvalid && !full;
    // refill output reg when idle or draining
    assign rd_en = (m.tready || !out_valid) && !empty;

    assign in_tready = !full;

    //////////////////////////////
    // write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    // output word, payload only
    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_beat <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // valid follows the refill decision
            if (m.tready || !out_valid) begin
                out_valid <= !empty;
            end
        end
    end

    assign m.tvalid = out_valid;
    assign m.tdata  = out_beat.tdata;
    assign m.tkeep  = out_beat.tkeep;
    assign m.tlast  = out_beat.tlast;
    assign m.tuser  = out_beat.tuser;

endmodule

`default_nettype wire

// File: rtl/axis_frame_meter.sv
// axis_frame_meter: pass-through stage that sizes each frame and emits a status record
`timescale 1ns/100ps
`default_nettype none

module axis_frame_meter #(
    parameter int unsigned MIN_FRAME_BYTES = 60
) (
    input  logic                     clk,
    input  logic                     rst,

    // stream in and out
    axis_if.snk                      s,
    axis_if.src                      m,

    // per-frame status
    output logic                     status_valid,
    output frame_pkg::frame_status_t status,
    input  logic                     status_ready
);

    localparam int LEN_W  = frame_pkg::LEN_WIDTH;
    localparam int KEEP_W = axis_pkg::KEEP_WIDTH;

    // bytes so far in the open frame
    logic [LEN_W-1:0]      byte_count;
    logic [LEN_W:0]        len_sum;
    logic [LEN_W-1:0]      frame_len;
    frame_pkg::frame_code_e code_next;

    logic                  hold;
    logic                  beat_xfer;
    logic                  last_xfer;

    // set keep bits of one beat
    function automatic logic [LEN_W-1:0] keep_bytes(input logic [KEEP_W-1:0] keep);
        logic [LEN_W-1:0] n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            n = n + LEN_W'(keep[i]);
        end
        return n;
    endfunction

    //////////////////////////////
    // stream pass-through
    //////////////////////////////

    // last beat waits while a record is still unread
    assign hold = s.tlast && status_valid;

    assign m.tvalid = s.tvalid && !hold;
    assign s.tready = m.tready && !hold;
    assign m.tdata  = s.tdata;
    assign m.tkeep  = s.tkeep;
    assign m.tlast  = s.tlast;
    assign m.tuser  = s.tuser;

    assign beat_xfer = s.tvalid && s.tready;
    assign last_xfer = beat_xfer && s.tlast;

    //////////////////////////////
    // length and code
    //////////////////////////////

    // extra bit catches overflow
    assign len_sum   = {1'b0, byte_count} + {1'b0, keep_bytes(s.tkeep)};
    assign frame_len = len_sum[LEN_W] ? {LEN_W{1'b1}} : len_sum[LEN_W-1:0];

    always_comb begin
        // error wins over runt
        if (s.tuser) begin
            code_next = frame_pkg::FRAME_ERROR;
        end else if (frame_len < LEN_W'(MIN_FRAME_BYTES)) begin
            code_next = frame_pkg::FRAME_RUNT;
        end else begin
            code_next = frame_pkg::FRAME_GOOD;
        end
    end

    //////////////////////////////
    // counters and status reg
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_count   <= '0;
            status_valid <= 1'b0;
        end else begin
            if (last_xfer) begin
                byte_count <= '0;
            end else if (beat_xfer) begin
                byte_count <= frame_len;
            end
            // new record only after the old one left
            if (last_xfer) begin
                status_valid <= 1'b1;
            end else if (status_ready) begin
                status_valid <= 1'b0;
            end
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (last_xfer) begin
            status.code <= code_next;
            status.len  <= frame_len;
        end
    end

endmodule

`default_nettype wire

// File: rtl/axis_frame_path.sv
// axis_frame_path: buffered 64-bit frame path with per-frame status output
`timescale 1ns/100ps
`default_nettype none

module axis_frame_path #(
    parameter int          FIFO_ADDR_WIDTH = 12,
    parameter int unsigned MIN_FRAME_BYTES = 60
) (
    input  logic                              clk,
    input  logic                              rst,

    //////////////////////////////
    // input stream
    //////////////////////////////
    input  logic [axis_pkg::DATA_WIDTH-1:0]   in_tdata,
    input  logic [axis_pkg::KEEP_WIDTH-1:0]   in_tkeep,
    input  logic                              in_tvalid,
    output logic                              in_tready,
    input  logic                              in_tlast,
    input  logic                              in_tuser,

    //////////////////////////////
    // output stream
    //////////////////////////////
    output logic [axis_pkg::DATA_WIDTH-1:0]   out_tdata,
    output logic [axis_pkg::KEEP_WIDTH-1:0]   out_tkeep,
    output logic                              out_tvalid,
    input  logic                              out_tready,
    output logic                              out_tlast,
    output logic                              out_tuser,

    //////////////////////////////
    // frame status
    //////////////////////////////
    output logic                              status_valid,
    output frame_pkg::frame_code_e            status_code,
    output logic [frame_pkg::LEN_WIDTH-1:0]   status_len,
    input  logic                              status_ready
);

    // internal stream hops
    axis_if fifo_to_meter ();
    axis_if meter_to_skid ();

    frame_pkg::frame_status_t status;

    // central buffer, absorbs back-pressure
    axis_fifo_64 #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_tdata  (in_tdata),
        .in_tkeep  (in_tkeep),
        .in_tvalid (in_tvalid),
        .in_tready (in_tready),
        .in_tlast  (in_tlast),
        .in_tuser  (in_tuser),
        .m         (fifo_to_meter)
    );

    // sizes frames, no added latency
    axis_frame_meter #(
        .MIN_FRAME_BYTES (MIN_FRAME_BYTES)
    ) u_meter (
        .clk          (clk),
        .rst          (rst),
        .s            (fifo_to_meter),
        .m            (meter_to_skid),
        .status_valid (status_valid),
        .status       (status),
        .status_ready (status_ready)
    );

    // registered output slice
    axis_skid_buffer u_skid (
        .clk        (clk),
        .rst        (rst),
        .s          (meter_to_skid),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser)
    );

    // split record onto flat ports
    assign status_code = status.code;
    assign status_len  = status.len;

endmodule

`default_nettype wire

// File: rtl/axis_if.sv
// axis_if: 64-bit stream bundle with source and sink views
`timescale 1ns/100ps
`default_nettype none

interface axis_if;

    // payload and sideband
    logic [axis_pkg::DATA_WIDTH-1:0] tdata;
    logic [axis_pkg::KEEP_WIDTH-1:0] tkeep;
    logic                            tlast;
    logic                            tuser;

    // handshake
    logic                            tvalid;
    logic                            tready;

    // source side drives all but ready
    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    // sink side only answers with ready
    modport snk (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

`default_nettype wire

// File: rtl/axis_pkg.sv
// axis_pkg: widths and beat layout of the 64-bit stream path
`default_nettype none

package axis_pkg;

    //////////////////////////////
    // stream widths
    //////////////////////////////

    // fixed datapath, one keep bit per byte
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    //////////////////////////////
    // beat word
    //////////////////////////////

    // one stored beat, sideband on top
    typedef struct packed {
        logic                  tlast;
        logic                  tuser;
        logic [KEEP_WIDTH-1:0] tkeep;
        logic [DATA_WIDTH-1:0] tdata;
    } axis_beat_t;

endpackage

`default_nettype wire

// File: rtl/axis_skid_buffer.sv
// axis_skid_buffer: two-entry register slice that breaks the ready path at the output
`timescale 1ns/100ps
`default_nettype none

module axis_skid_buffer (
    input  logic                            clk,
    input  logic                            rst,

    // stream from the meter
    axis_if.snk                             s,

    // plain output stream
    output logic [axis_pkg::DATA_WIDTH-1:0] out_tdata,
    output logic [axis_pkg::KEEP_WIDTH-1:0] out_tkeep,
    output logic                            out_tvalid,
    input  logic                            out_tready,
    output logic                            out_tlast,
    output logic                            out_tuser
);

    axis_pkg::axis_beat_t in_beat;
    axis_pkg::axis_beat_t main_q;
    axis_pkg::axis_beat_t skid_q;
    logic                 main_valid;
    logic                 skid_valid;
    logic                 ready_q;
    logic                 ready_d;

    assign in_beat.tdata = s.tdata;
    assign in_beat.tkeep = s.tkeep;
    assign in_beat.tlast = s.tlast;
    assign in_beat.tuser = s.tuser;

    // upstream only sees the registered ready
    assign s.tready = ready_q;

    // stay open if drained, or skid stays free this cycle
    assign ready_d = out_tready || (!skid_valid && (!main_valid || !s.tvalid));

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q    <= 1'b0;
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            ready_q <= ready_d;
            if (ready_q) begin
                // input straight to main, or park it in skid
                if (out_tready || !main_valid) begin
                    main_valid <= s.tvalid;
                end else begin
                    skid_valid <= s.tvalid;
                end
            end else if (out_tready) begin
                main_valid <= skid_valid;
                skid_valid <= 1'b0;
            end
        end
    end

    // payload moves the same way
    always_ff @(posedge clk) begin
        if (ready_q) begin
            if (out_tready || !main_valid) begin
                main_q <= in_beat;
            end else begin
                skid_q <= in_beat;
            end
        end else if (out_tready) begin
            main_q <= skid_q;
        end
    end

    assign out_tvalid = main_valid;
    assign out_tdata  = main_q.tdata;
    assign out_tkeep  = main_q.tkeep;
    assign out_tlast  = main_q.tlast;
    assign out_tuser  = main_q.tuser;

endmodule

`default_nettype wire

// File: rtl/frame_pkg.sv
// frame_pkg: frame status codes and the per-frame status record
`default_nettype none

package frame_pkg;

    //////////////////////////////
    // frame length
    //////////////////////////////

    // byte count width, saturates at the top
    localparam int LEN_WIDTH = 16;

    //////////////////////////////
    // status record
    //////////////////////////////

    // outcome of one frame
    typedef enum logic [1:0] {
        FRAME_GOOD  = 2'd0,
        FRAME_ERROR = 2'd1,
        FRAME_RUNT  = 2'd2
    } frame_code_e;

    // one record per frame, code above length
    typedef struct packed {
        frame_code_e          code;
        logic [LEN_WIDTH-1:0] len;
    } frame_status_t;

endpackage

`default_nettype wire

// File: sources.f
rtl/axis_pkg.sv
rtl/frame_pkg.sv
rtl/axis_if.sv
rtl/axis_fifo_64.sv
rtl/axis_frame_meter.sv
rtl/axis_skid_buffer.sv
rtl/axis_frame_path.sv
testbench/tb_clock_gen.sv
testbench/tb_axis_frame_path.sv

// File: testbench/tb_axis_frame_path.sv
// tb_axis_frame_path drives random and directed frames through the frame path under assertions
`timescale 1ns/100ps
`default_nettype none

module tb_axis_frame_path;

    localparam int FIFO_AW   = 4;
    localparam int MIN_BYTES = 60;
    localparam int RAND_FRAMES  = 12;
    localparam int STALL_FRAMES = 10;
    localparam int FILL_BEATS   = 30;
    // upper bound on beats over all tests with the directed frames
    localparam int TOTAL_BEATS  = (RAND_FRAMES + STALL_FRAMES) * 20 + 39 + FILL_BEATS;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40;

    logic                            clk;
    logic                            rst;
    logic [axis_pkg::DATA_WIDTH-1:0] in_tdata;
    logic [axis_pkg::KEEP_WIDTH-1:0] in_tkeep;
    logic                            in_tvalid;
    logic                            in_tready;
    logic                            in_tlast;
    logic                            in_tuser;
    logic [axis_pkg::DATA_WIDTH-1:0] out_tdata;
    logic [axis_pkg::KEEP_WIDTH-1:0] out_tkeep;
    logic                            out_tvalid;
    logic                            out_tready;
    logic                            out_tlast;
    logic                            out_tuser;
    logic                            status_valid;
    frame_pkg::frame_code_e          status_code;
    logic [frame_pkg::LEN_WIDTH-1:0] status_len;
    logic                            status_ready;

    //////////////////////////////
    // scoreboard state
    //////////////////////////////

    axis_pkg::axis_beat_t     sent_q[$];
    frame_pkg::frame_status_t stat_q[$];
    axis_pkg::axis_beat_t     sent_head;
    frame_pkg::frame_status_t stat_head;
    logic                     sent_empty;
    logic                     stat_empty;

    logic [15:0] lfsr_state;
    // 0 always ready, 1 random, 2 held low
    int out_mode;
    int stat_mode;
    // ready levels for the next falling edge
    logic out_ready_next;
    logic stat_ready_next;
    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    tb_clock_gen u_clk (.clk(clk));

    axis_frame_path #(
        .FIFO_ADDR_WIDTH (FIFO_AW),
        .MIN_FRAME_BYTES (MIN_BYTES)
    ) DUT (
        .clk(clk), .rst(rst),
        .in_tdata(in_tdata), .in_tkeep(in_tkeep), .in_tvalid(in_tvalid),
        .in_tready(in_tready), .in_tlast(in_tlast), .in_tuser(in_tuser),
        .out_tdata(out_tdata), .out_tkeep(out_tkeep), .out_tvalid(out_tvalid),
        .out_tready(out_tready), .out_tlast(out_tlast), .out_tuser(out_tuser),
        .status_valid(status_valid), .status_code(status_code),
        .status_len(status_len), .status_ready(status_ready)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // contiguous low bytes
    function automatic logic [7:0] keep_for(input int n);
        logic [8:0] k;
        k = (9'd1 << n) - 9'd1;
        return k[7:0];
    endfunction

    function automatic void refresh_heads();
        sent_empty = (sent_q.size() == 0);
        stat_empty = (stat_q.size() == 0);
        sent_head  = sent_empty ? '0 : sent_q[0];
        stat_head  = stat_empty ? '0 : stat_q[0];
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("FAIL t=%0t %s", $time, msg);
    endtask

    task automatic note_problem(input string msg);
        errors++;
        $display("problem at %0t ns: %s", $time, msg);
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    a_out_beat: assert property (@(posedge clk) disable iff (rst)
        (out_tvalid && out_tready) |->
            (!sent_empty && {out_tlast, out_tuser, out_tkeep, out_tdata} == sent_head))
        else note_failure("output beat is not the next sent beat");

    a_status: assert property (@(posedge clk) disable iff (rst)
        (status_valid && status_ready) |->
            (!stat_empty && {status_code, status_len} == stat_head))
        else note_failure("status record is not the next expected record");

    // pop on each transfer with the values from before the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (out_tvalid && out_tready && !sent_empty) begin
                sent_q.delete(0);
            end
            if (status_valid && status_ready && !stat_empty) begin
                stat_q.delete(0);
            end
            refresh_heads();
        end
    end

    // stall bits drawn on the rising edge, away from the frame draws
    always @(posedge clk) begin
        if (!rst) begin
            out_ready_next  = (out_mode == 0) ? 1'b1 :
                              (out_mode == 1) ? (take_bits(1) != 0) : 1'b0;
            stat_ready_next = (stat_mode == 0) ? 1'b1 :
                              (stat_mode == 1) ? (take_bits(1) != 0) : 1'b0;
        end
    end

    // ready stall patterns
    always @(negedge clk) begin
        if (!rst) begin
            out_tready   = out_ready_next;
            status_ready = stat_ready_next;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // enters and leaves on a falling edge
    task automatic send_beat(input axis_pkg::axis_beat_t beat);
        in_tdata  = beat.tdata;
        in_tkeep  = beat.tkeep;
        in_tlast  = beat.tlast;
        in_tuser  = beat.tuser;
        in_tvalid = 1'b1;
        while (!in_tready) @(negedge clk);
        // accepted at the coming rising edge
        sent_q.push_back(beat);
        refresh_heads();
        @(negedge clk);
        in_tvalid = 1'b0;
    endtask

    // user_mode 0 keeps tuser clear, 1 sets it on the last beat, 2 draws it per beat
    task automatic send_frame(input int nbeats, input int last_bytes, input int user_mode);
        axis_pkg::axis_beat_t     beats[$];
        axis_pkg::axis_beat_t     beat;
        frame_pkg::frame_status_t rec;
        int                       bytes;
        for (int b = 0; b < nbeats; b++) begin
            beat.tdata = take_bits(64);
            beat.tlast = (b == nbeats - 1);
            beat.tkeep = beat.tlast ? keep_for(last_bytes) : 8'hff;
            if (user_mode == 0) begin
                beat.tuser = 1'b0;
            end else if (user_mode == 1) begin
                beat.tuser = beat.tlast;
            end else begin
                beat.tuser = (take_bits(3) == 0);
            end
            beats.push_back(beat);
        end
        bytes    = (nbeats - 1) * 8 + last_bytes;
        rec.len  = bytes[15:0];
        // error wins over runt
        if (beat.tuser) begin
            rec.code = frame_pkg::FRAME_ERROR;
        end else if (bytes < MIN_BYTES) begin
            rec.code = frame_pkg::FRAME_RUNT;
        end else begin
            rec.code = frame_pkg::FRAME_GOOD;
        end
        stat_q.push_back(rec);
        refresh_heads();
        foreach (beats[i]) begin
            send_beat(beats[i]);
        end
    endtask

    task automatic send_random_frames(input int count);
        for (int f = 0; f < count; f++) begin
            send_frame(1 + int'(take_bits(5)) % 20, 1 + int'(take_bits(3)), 2);
        end
    endtask

    // done when both queues are empty
    task automatic wait_drain();
        while (!sent_empty || !stat_empty) @(negedge clk);
        @(negedge clk);
        assert (!out_tvalid && !status_valid)
            else note_failure("output still valid after every expected item arrived");
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
        errors_at_start = errors;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int waited;
        rst = 1'b1;
        in_tdata = '0;
        in_tkeep = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        out_tready = 1'b1;
        status_ready = 1'b1;
        out_ready_next = 1'b1;
        stat_ready_next = 1'b1;
        lfsr_state = 16'd35;
        out_mode = 0;
        stat_mode = 0;
        errors = 0;
        errors_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        refresh_heads();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        assert (!out_tvalid && !status_valid && in_tready)
            else note_failure("outputs not idle after reset");
        finish_test("reset_state");

        send_random_frames(RAND_FRAMES);
        wait_drain();
        finish_test("random_frames");

        // runt edge at 59 and 60 bytes, then long and short frames with tuser set
        send_frame(8, 3, 0);
        send_frame(8, 4, 0);
        send_frame(20, 8, 1);
        send_frame(2, 5, 1);
        send_frame(1, 1, 0);
        wait_drain();
        finish_test("length_and_codes");

        out_mode = 2;
        fork
            send_frame(FILL_BEATS, 8, 0);
            begin
                waited = 0;
                while (in_tready && waited < 200) begin
                    @(negedge clk);
                    waited++;
                end
                if (in_tready) begin
                    note_problem("in_tready stayed high while the output was stalled");
                end
                repeat (6) @(negedge clk);
                out_mode = 0;
            end
        join
        wait_drain();
        finish_test("backpressure");

        out_mode = 1;
        stat_mode = 1;
        send_random_frames(STALL_FRAMES);
        wait_drain();
        out_mode = 0;
        stat_mode = 0;
        finish_test("status_stall");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// tb_clock_gen: free-running testbench clock, 4 ns period
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    // starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire
